// File: logic/pad_frame_pkg.sv
// Pad frame package
// Pad counts, JTAG overlay indices, pad attribute and APB types

package pad_frame_pkg;

  ////////////////////
  // Pad counts
  ////////////////////

  localparam int num_mio_pads = 8;                            // Muxed pads
  localparam int num_dio_pads = 4;                            // Dedicated pads
  localparam int num_pads     = num_mio_pads + num_dio_pads;  // MIO low, DIO high

  typedef logic [num_pads-1:0]   pad_vec_t;                   // One bit per pad
  typedef logic [1:0]            pad_attr_t;                  // Attribute of one pad
  typedef logic [2*num_pads-1:0] pad_attr_vec_t;              // Pad n at bits 2n+1..2n

  localparam int attr_inv_bit = 0;                            // Invert
  localparam int attr_od_bit  = 1;                            // Open drain

  typedef struct packed {
    pad_vec_t out;                                            // Output level
    pad_vec_t oe;                                             // Output enable
  } pad_drive_t;

  ////////////////////
  // JTAG overlay
  ////////////////////

  localparam int jtag_en_idx = 7;                             // MIO 7
  localparam int tck_idx     = num_mio_pads + 0;              // DIO 0
  localparam int tms_idx     = num_mio_pads + 1;              // DIO 1
  localparam int tdi_idx     = num_mio_pads + 2;              // DIO 2
  localparam int tdo_idx     = num_mio_pads + 3;              // DIO 3

  // TMS pad doubles as an active-low chip select, so park it high
  localparam pad_vec_t jtag_tie_off = pad_vec_t'(1) << tms_idx;

  ////////////////////
  // APB
  ////////////////////

  typedef logic [3:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  localparam int mio_attr_w = 2 * num_mio_pads;               // 16 bits
  localparam int dio_attr_w = 2 * num_dio_pads;               // 8 bits

  localparam apb_addr_t mio_attr_addr = 4'h0;                 // Bits 15..0
  localparam apb_addr_t dio_attr_addr = 4'h4;                 // Bits 7..0

endpackage : pad_frame_pkg

// File: logic/pad_attr_regs.sv
// Pad attribute registers
// APB slave holding the MIO and DIO invert/open-drain attributes

`timescale 1ns/10ps

module pad_attr_regs
  import pad_frame_pkg::*;
(
  input  logic          clk_i,       // Bus clock
  input  logic          arst_n_i,    // Async reset, active low
  input  apb_req_t      apb_req_i,   // APB request
  output apb_rsp_t      apb_rsp_o,   // APB response
  output pad_attr_vec_t pad_attr_o   // All pad attributes
);

  ////////////////////
  // Decode
  ////////////////////

  logic                  access;     // Access phase of a transfer
  logic                  hit_mio;    // MIO register selected
  logic                  hit_dio;    // DIO register selected
  logic                  mapped;     // Any register selected
  logic                  wr_mio;     // MIO write strobe
  logic                  wr_dio;     // DIO write strobe
  logic [mio_attr_w-1:0] mio_attr_q; // MIO attributes
  logic [dio_attr_w-1:0] dio_attr_q; // DIO attributes
  apb_data_t             rdata;      // Selected read value

  assign access  = apb_req_i.psel & apb_req_i.penable;  // Second cycle of transfer
  assign hit_mio = (apb_req_i.paddr == mio_attr_addr);
  assign hit_dio = (apb_req_i.paddr == dio_attr_addr);
  assign mapped  = hit_mio | hit_dio;

  assign wr_mio = access & apb_req_i.pwrite & hit_mio;
  assign wr_dio = access & apb_req_i.pwrite & hit_dio;

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mio_attr_q <= '0;                                   // Plain pads after reset
      dio_attr_q <= '0;
    end else begin
      if (wr_mio) begin
        mio_attr_q <= apb_req_i.pwdata[mio_attr_w-1:0];   // Keep low 16 bits
      end
      if (wr_dio) begin
        dio_attr_q <= apb_req_i.pwdata[dio_attr_w-1:0];   // Keep low 8 bits
      end
    end
  end

  ////////////////////
  // Read path
  ////////////////////

  always_comb begin
    rdata = '0;                                           // Unmapped reads as zero
    if (hit_mio) begin
      rdata = apb_data_t'(mio_attr_q);                    // Upper bits zero
    end else if (hit_dio) begin
      rdata = apb_data_t'(dio_attr_q);
    end
  end

  // Response only in the access cycle, no wait states
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.pslverr = access & ~mapped;            // Bad address
  assign apb_rsp_o.prdata  = (access && !apb_req_i.pwrite) ? rdata : '0;

  // DIO pads sit above MIO pads in the attribute vector
  assign pad_attr_o = {dio_attr_q, mio_attr_q};

endmodule : pad_attr_regs

// File: logic/jtag_overlay_mux.sv
// JTAG overlay mux
// Hands four DIO pads to the JTAG port while the enable pad is high

`timescale 1ns/10ps

module jtag_overlay_mux
  import pad_frame_pkg::*;
(
  // Core side
  input  pad_drive_t core_drive_i,   // Core out/oe
  output pad_vec_t   core_in_o,      // Pad inputs seen by core
  // Pad cell side
  input  pad_vec_t   pad_in_i,       // De-inverted pad inputs
  output pad_drive_t mux_drive_o,    // Out/oe toward pad cells
  // JTAG port
  output logic       jtag_tck_o,
  output logic       jtag_tms_o,
  output logic       jtag_tdi_o,
  input  logic       jtag_tdo_i,
  output logic       jtag_active_o   // Overlay engaged
);

  ////////////////////
  // Enable
  ////////////////////

  // Enable pad is sampled straight from the pin, no sync
  assign jtag_active_o = pad_in_i[jtag_en_idx];

  ////////////////////
  // Overlay
  ////////////////////

  always_comb begin
    // Default is full pass-through
    mux_drive_o = core_drive_i;
    core_in_o   = pad_in_i;
    jtag_tck_o  = 1'b0;                              // Parked when inactive
    jtag_tms_o  = 1'b0;
    jtag_tdi_o  = 1'b0;

    if (jtag_active_o) begin
      // Pad to JTAG
      jtag_tck_o = pad_in_i[tck_idx];
      jtag_tms_o = pad_in_i[tms_idx];
      jtag_tdi_o = pad_in_i[tdi_idx];

      // JTAG inputs are never driven
      mux_drive_o.oe[tck_idx] = 1'b0;
      mux_drive_o.oe[tms_idx] = 1'b0;
      mux_drive_o.oe[tdi_idx] = 1'b0;

      // TDO owns its pad
      mux_drive_o.out[tdo_idx] = jtag_tdo_i;
      mux_drive_o.oe[tdo_idx]  = 1'b1;

      // Core sees idle values on the borrowed pads
      core_in_o[tck_idx] = jtag_tie_off[tck_idx];
      core_in_o[tms_idx] = jtag_tie_off[tms_idx];    // CSB held inactive
      core_in_o[tdi_idx] = jtag_tie_off[tdi_idx];
      core_in_o[tdo_idx] = jtag_tie_off[tdo_idx];
    end
  end

endmodule : jtag_overlay_mux

// File: logic/pad_cell_array.sv
// Pad cell array
// Per-pad invert and open-drain behavior between the overlay mux and the pins

`timescale 1ns/10ps

module pad_cell_array
  import pad_frame_pkg::*;
(
  input  pad_attr_vec_t pad_attr_i,  // Attributes from registers
  input  pad_drive_t    drive_i,     // Out/oe from overlay mux
  output pad_vec_t      pad_in_o,    // De-inverted input toward mux
  output pad_vec_t      pad_out_o,   // Pin output level
  output pad_vec_t      pad_oe_o,    // Pin output enable
  input  pad_vec_t      pad_in_i     // Pin input level
);

  ////////////////////
  // Cells
  ////////////////////

  for (genvar i = 0; i < num_pads; i++) begin : g_pad
    pad_attr_t attr;                 // This pad's attribute
    logic      inv;                  // Invert enabled
    logic      od;                   // Open drain enabled
    logic      level;                // Driven level after invert

    assign attr  = pad_attr_i[2*i +: 2];
    assign inv   = attr[attr_inv_bit];
    assign od    = attr[attr_od_bit];
    assign level = drive_i.out[i] ^ inv;

    // Open drain only ever pulls low
    assign pad_out_o[i] = od ? 1'b0 : level;
    assign pad_oe_o[i]  = od ? (drive_i.oe[i] & ~level) : drive_i.oe[i];

    // Input path undoes the invert
    assign pad_in_o[i] = pad_in_i[i] ^ inv;
  end

endmodule : pad_cell_array

// File: logic/pad_frame_top.sv
// Pad frame top level
// Attribute registers, JTAG overlay mux and pad cells for 8 MIO and 4 DIO pads

`timescale 1ns/10ps

module pad_frame_top
  import pad_frame_pkg::*;
(
  input  logic       clk_i,          // APB clock
  input  logic       arst_n_i,       // Async reset, active low
  // Register bus
  input  apb_req_t   apb_req_i,
  output apb_rsp_t   apb_rsp_o,
  // Core side
  input  pad_drive_t core_drive_i,   // Core out/oe
  output pad_vec_t   core_in_o,      // Pad inputs to core
  // Pins
  output pad_vec_t   pad_out_o,
  output pad_vec_t   pad_oe_o,
  input  pad_vec_t   pad_in_i,
  // JTAG port
  output logic       jtag_tck_o,
  output logic       jtag_tms_o,
  output logic       jtag_tdi_o,
  input  logic       jtag_tdo_i,
  output logic       jtag_active_o
);

  pad_attr_vec_t pad_attr;           // Register to cells
  pad_drive_t    mux_drive;          // Mux to cells
  pad_vec_t      pad_in;             // Cells to mux

  ////////////////////
  // Registers
  ////////////////////

  pad_attr_regs pad_attr_regs_inst (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .apb_req_i  ( apb_req_i  ),
    .apb_rsp_o  ( apb_rsp_o  ),
    .pad_attr_o ( pad_attr   )
  );

  ////////////////////
  // Overlay mux
  ////////////////////

  jtag_overlay_mux jtag_overlay_mux_inst (
    .core_drive_i  ( core_drive_i  ),
    .core_in_o     ( core_in_o     ),
    .pad_in_i      ( pad_in        ),  // Already de-inverted
    .mux_drive_o   ( mux_drive     ),
    .jtag_tck_o    ( jtag_tck_o    ),
    .jtag_tms_o    ( jtag_tms_o    ),
    .jtag_tdi_o    ( jtag_tdi_o    ),
    .jtag_tdo_i    ( jtag_tdo_i    ),
    .jtag_active_o ( jtag_active_o )
  );

  ////////////////////
  // Pad cells
  ////////////////////

  pad_cell_array pad_cell_array_inst (
    .pad_attr_i ( pad_attr  ),
    .drive_i    ( mux_drive ),
    .pad_in_o   ( pad_in    ),
    .pad_out_o  ( pad_out_o ),
    .pad_oe_o   ( pad_oe_o  ),
    .pad_in_i   ( pad_in_i  )
  );

endmodule : pad_frame_top

// File: verification/pad_frame_checker.sv
// Pad frame checker
// Bound assertions on APB responses, open-drain pins and the JTAG TDO pad

`timescale 1ns/10ps

module pad_frame_checker
  import pad_frame_pkg::*;
(
  input logic          clk_i,
  input logic          arst_n_i,
  input apb_req_t      apb_req_i,
  input apb_rsp_t      apb_rsp_i,
  input pad_attr_vec_t pad_attr_i,     // Register outputs
  input pad_vec_t      pad_out_i,
  input pad_vec_t      pad_oe_i,
  input logic          jtag_active_i
);

  pad_vec_t od_mask;                   // Pads set to open drain

  always_comb begin
    for (int i = 0; i < num_pads; i++) begin
      od_mask[i] = pad_attr_i[2*i+1];
    end
  end

  ////////////////////
  // APB
  ////////////////////

  a_pready_access : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    apb_rsp_i.pready |-> (apb_req_i.psel && apb_req_i.penable))
    else $error("pready outside an access cycle");

  a_pslverr_pready : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    apb_rsp_i.pslverr |-> apb_rsp_i.pready)
    else $error("pslverr without pready");

  ////////////////////
  // Pads
  ////////////////////

  a_od_no_high : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (od_mask & pad_oe_i & pad_out_i) == '0)
    else $error("open-drain pad drives high");

  // Plain TDO pad carries the forced oe out to the pin
  a_tdo_oe : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (jtag_active_i && !od_mask[tdo_idx]) |-> pad_oe_i[tdo_idx])
    else $error("TDO pad not enabled while JTAG active");

endmodule : pad_frame_checker

// File: verification/pad_frame_tb.sv
// Pad frame testbench
// Directed tests for the attribute registers, pad cell rules and JTAG overlay

`timescale 1ns/10ps

module pad_frame_tb;
  import pad_frame_pkg::*;

  localparam int num_tests    = 5;
  localparam int reset_cycles = 10;
  localparam int test_cycles  = 200;                  // Budget per test

  logic          clk;
  logic          arst_n;
  apb_req_t      apb_req;
  apb_rsp_t      apb_rsp;
  pad_drive_t    core_drive;
  pad_vec_t      core_in, pad_out, pad_oe, pad_in;
  logic          jtag_tck, jtag_tms, jtag_tdi, jtag_tdo, jtag_active;
  pad_attr_vec_t attr_model;                          // Expected register contents
  integer        seed = 32'hce496cd6;

  pad_frame_top pad_frame_top_inst (
    .clk_i(clk), .arst_n_i(arst_n), .apb_req_i(apb_req), .apb_rsp_o(apb_rsp),
    .core_drive_i(core_drive), .core_in_o(core_in), .pad_out_o(pad_out),
    .pad_oe_o(pad_oe), .pad_in_i(pad_in), .jtag_tck_o(jtag_tck), .jtag_tms_o(jtag_tms),
    .jtag_tdi_o(jtag_tdi), .jtag_tdo_i(jtag_tdo), .jtag_active_o(jtag_active)
  );

  bind pad_frame_top pad_frame_checker pad_frame_checker_inst (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .apb_req_i(apb_req_i), .apb_rsp_i(apb_rsp_o),
    .pad_attr_i(pad_attr), .pad_out_i(pad_out_o), .pad_oe_i(pad_oe_o),
    .jtag_active_i(jtag_active_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                           // 20 ns period
  end

  // Watchdog sized from the test budget
  initial begin
    repeat (reset_cycles + num_tests * test_cycles) @(posedge clk);
    $display("Watchdog expired: the tests did not finish in time");
    $display("=== FAIL ===");
    $fatal(1, "Run stopped by watchdog");
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, act, exp);
      $display("=== FAIL ===");
      $fatal(1, "Stopping on first error");
    end
  endtask

  // Access phase shared by reads and writes
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
    @(posedge clk);
    apb_req.psel    <= 1'b1;                          // Setup cycle
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;                          // Access cycle
    @(negedge clk);
    check_eq("pready", apb_rsp.pready, 1'b1);         // No wait states
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    check_eq("pslverr", err, (addr != 4'h0) && (addr != 4'h4));
    @(posedge clk);                                   // Write lands here
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t rd;
    logic      err;
    apb_xfer(1'b1, addr, data, rd, err);
    if (addr == 4'h0) attr_model[15:0] = data[15:0];  // Keep low 16 bits
    if (addr == 4'h4) attr_model[23:16] = data[7:0];  // Keep low 8 bits
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    logic err;
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  // Expected pins, core inputs and JTAG {active, tdi, tms, tck}
  task automatic pad_model(input pad_attr_vec_t attr, input pad_vec_t d_out, d_oe, pin,
                           input logic tdo, output pad_vec_t e_out, e_oe, e_core,
                           output logic [3:0] e_jtag);
    pad_vec_t inv, od, pin_eff, m_out, m_oe;
    logic     level;
    for (int i = 0; i < num_pads; i++) begin
      inv[i] = attr[2*i];
      od[i]  = attr[2*i+1];
    end
    pin_eff = pin ^ inv;                              // De-inverted inputs
    m_out   = d_out;
    m_oe    = d_oe;
    e_core  = pin_eff;
    e_jtag  = 4'b0000;
    if (pin_eff[jtag_en_idx]) begin
      e_jtag = {1'b1, pin_eff[tdi_idx], pin_eff[tms_idx], pin_eff[tck_idx]};
      m_oe[tck_idx] = 1'b0;
      m_oe[tms_idx] = 1'b0;
      m_oe[tdi_idx] = 1'b0;
      m_out[tdo_idx] = tdo;
      m_oe[tdo_idx]  = 1'b1;
      e_core[tck_idx] = 1'b0;
      e_core[tms_idx] = 1'b1;                         // Chip select parked inactive
      e_core[tdi_idx] = 1'b0;
      e_core[tdo_idx] = 1'b0;
    end
    for (int i = 0; i < num_pads; i++) begin
      level    = m_out[i] ^ inv[i];
      e_out[i] = od[i] ? 1'b0 : level;
      e_oe[i]  = od[i] ? (m_oe[i] & ~level) : m_oe[i];
    end
  endtask

  // enable_level is the de-inverted level wanted on the JTAG enable pad
  task automatic drive_and_check_pads(input logic enable_level);
    pad_vec_t d_out, d_oe, pin, e_out, e_oe, e_core;
    logic     tdo;
    logic [3:0] e_jtag;
    d_out = pad_vec_t'($random(seed));
    d_oe  = pad_vec_t'($random(seed));
    pin   = pad_vec_t'($random(seed));
    tdo   = $random(seed);
    pin[jtag_en_idx] = enable_level ^ attr_model[2*jtag_en_idx];
    @(posedge clk);
    core_drive.out <= d_out;
    core_drive.oe  <= d_oe;
    pad_in         <= pin;
    jtag_tdo       <= tdo;
    @(negedge clk);
    pad_model(attr_model, d_out, d_oe, pin, tdo, e_out, e_oe, e_core, e_jtag);
    check_eq("pad_out_o", pad_out, e_out);
    check_eq("pad_oe_o", pad_oe, e_oe);
    check_eq("core_in_o", core_in, e_core);
    check_eq("jtag_active_o", jtag_active, e_jtag[3]);
    check_eq("jtag_tdi_o", jtag_tdi, e_jtag[2]);
    check_eq("jtag_tms_o", jtag_tms, e_jtag[1]);
    check_eq("jtag_tck_o", jtag_tck, e_jtag[0]);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_state();
    apb_data_t rd;
    check_eq("pready", apb_rsp.pready, 1'b0);         // Idle bus
    check_eq("pslverr", apb_rsp.pslverr, 1'b0);
    apb_read(4'h0, rd);
    check_eq("prdata mio", rd, 32'h0);
    apb_read(4'h4, rd);
    check_eq("prdata dio", rd, 32'h0);
    repeat (8) drive_and_check_pads(1'b0);            // Plain pass-through
  endtask

  task automatic test_attr_readback();
    apb_data_t wd_mio, wd_dio, rd;
    repeat (6) begin
      wd_mio = $random(seed);
      wd_dio = $random(seed);
      apb_write(4'h0, wd_mio);
      apb_write(4'h4, wd_dio);
      apb_read(4'h0, rd);
      check_eq("prdata mio", rd, {16'h0, wd_mio[15:0]});
      apb_read(4'h4, rd);
      check_eq("prdata dio", rd, {24'h0, wd_dio[7:0]});
    end
  endtask

  task automatic test_pad_rules();
    repeat (8) begin
      apb_write(4'h0, $random(seed));
      apb_write(4'h4, $random(seed));
      repeat (4) drive_and_check_pads(1'b0);
    end
  endtask

  task automatic test_jtag_overlay();
    apb_write(4'h4, 32'h0);                           // JTAG pads plain
    repeat (6) begin
      apb_write(4'h0, $random(seed));
      repeat (4) drive_and_check_pads(1'b1);
    end
    drive_and_check_pads(1'b0);                       // Release overlay
  endtask

  task automatic test_unmapped();
    apb_data_t rd;
    logic      err;
    apb_write(4'h4, $random(seed));
    apb_write(4'h8, $random(seed));                   // Ignored
    apb_write(4'h2, $random(seed));
    apb_xfer(1'b0, 4'hc, '0, rd, err);
    check_eq("prdata unmapped", rd, 32'h0);
    check_eq("pslverr unmapped", err, 1'b1);
    apb_read(4'h0, rd);
    check_eq("prdata mio", rd, {16'h0, attr_model[15:0]});
    apb_read(4'h4, rd);
    check_eq("prdata dio", rd, {24'h0, attr_model[23:16]});
  endtask

  initial begin
    arst_n     = 1'b0;
    apb_req    = '0;
    core_drive = '0;
    pad_in     = '0;
    jtag_tdo   = 1'b0;
    attr_model = '0;
    repeat (reset_cycles) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    test_reset_state();
    test_attr_readback();
    test_pad_rules();
    test_jtag_overlay();
    test_unmapped();
    $display("=== PASS ===");
    $finish;
  end

endmodule : pad_frame_tb

// File: pad_frame_top.f
logic/pad_frame_pkg.sv
logic/pad_attr_regs.sv
logic/jtag_overlay_mux.sv
logic/pad_cell_array.sv
logic/pad_frame_top.sv
verification/pad_frame_checker.sv
verification/pad_frame_tb.sv

// File: Bender.yml
package:
  name: pad_frame

sources:
  - logic/pad_frame_pkg.sv
  - logic/pad_attr_regs.sv
  - logic/jtag_overlay_mux.sv
  - logic/pad_cell_array.sv
  - logic/pad_frame_top.sv
  - target: simulation
    files:
      - verification/pad_frame_checker.sv
      - verification/pad_frame_tb.sv
